/* list.f */
+incdir+src
src/uart_pkg.sv
src/spi_pkg.sv
src/reset_stretch.sv
src/uart_rx.sv
src/uart_tx.sv
src/spi_frame_builder.sv
src/spi_master.sv
src/readback_queue.sv
src/bridge_top.sv
tests/tb_clock_gen.sv
tests/tb_bridge.sv

/* run.sh */
#!/usr/bin/env bash
# build with verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"
verilator --binary --timing --assert --top-module tb_bridge -f list.f -o tb_bridge \
  && ./obj_dir/tb_bridge > "$log" 2>&1 \
  || echo "Simulation failed" >> "$log"
cat "$log"
! grep -q "Simulation failed" "$log"

/* src/bridge_params.svh */
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

//////////////////////////////
// uart timing
// 50 MHz sys_clk, 115200 baud
`define BRIDGE_CLKS_PER_BIT 434

//////////////////////////////
// spi timing
// sys_clk cycles per sclk half period
`define BRIDGE_SPI_HALF_PERIOD 4
// address byte plus data byte
`define BRIDGE_FRAME_BITS 16

//////////////////////////////
// chip reset and readback
// at 50 MHz ten clocks give 200 ns, well over the chip's minimum
`define BRIDGE_RESET_STRETCH 4'd10
`define BRIDGE_QUEUE_DEPTH 4

`endif

/* src/bridge_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bridge_params.svh"

module bridge_top
  import uart_pkg::*, spi_pkg::*;
(
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  input  logic spi_miso_i,
  output logic spi_mosi_o,
  output logic spi_sclk_o,
  output logic spi_cs_n_o,
  output logic slm_reset_n_o
);

  uart_byte_s rx_byte;
  spi_req_s   spi_req;
  uart_byte_s rd_byte;
  uart_byte_s tx_byte;
  logic       tx_active;

  // chip reset, stretched past the command
  reset_stretch reset_stretch0 (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .slm_reset_n_o   (slm_reset_n_o)
  );

  //////////////////////////////
  // host to chip path
  uart_rx #(
    .CLKS_PER_BIT (`BRIDGE_CLKS_PER_BIT)
  ) uart_rx0 (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .rx_byte_o       (rx_byte)
  );

  spi_frame_builder spi_frame_builder0 (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_byte_i       (rx_byte),
    .spi_req_o       (spi_req)
  );

  spi_master spi_master0 (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .spi_req_i       (spi_req),
    .spi_miso_i      (spi_miso_i),
    .spi_mosi_o      (spi_mosi_o),
    .spi_sclk_o      (spi_sclk_o),
    .spi_cs_n_o      (spi_cs_n_o),
    .rd_byte_o       (rd_byte)
  );

  //////////////////////////////
  // readback to host
  readback_queue readback_queue0 (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rd_byte_i       (rd_byte),
    .tx_active_i     (tx_active),
    .tx_byte_o       (tx_byte)
  );

  uart_tx #(
    .CLKS_PER_BIT (`BRIDGE_CLKS_PER_BIT)
  ) uart_tx0 (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .tx_byte_i       (tx_byte),
    .uart_tx_o       (uart_tx_o),
    .tx_active_o     (tx_active)
  );

endmodule

`default_nettype wire

/* src/readback_queue.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bridge_params.svh"

module readback_queue
  import uart_pkg::*;
(
  input  logic       sys_clk,
  input  logic       reset_all_cmd_w,
  input  uart_byte_s rd_byte_i,
  input  logic       tx_active_i,
  output uart_byte_s tx_byte_o
);

  localparam int DEPTH = `BRIDGE_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

  logic [7:0]       mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             start_q;
  logic [7:0]       data_q;
  logic             push;
  logic             pop;

  // full queue drops the byte
  assign push = rd_byte_i.strobe && (count_q != CNT_FULL);
  // no pop while a start is pending, tx_active rises a cycle later
  assign pop  = (count_q != '0) && !tx_active_i && !start_q;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      start_q  <= 1'b0;
    end else begin
      // transmitter starts the cycle after the pop
      start_q <= pop;
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // storage and output byte
  always_ff @(posedge sys_clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= rd_byte_i.data;
    end
    if (pop) begin
      data_q <= mem_q[rd_ptr_q];
    end
  end

  assign tx_byte_o.strobe = start_q;
  assign tx_byte_o.data   = data_q;

  a_count_in_range : assert property (
    @(posedge sys_clk) disable iff (reset_all_cmd_w)
    count_q <= CNT_FULL
  ) else $error("readback_queue count above depth");

endmodule

`default_nettype wire

/* src/reset_stretch.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bridge_params.svh"

module reset_stretch (
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  output logic slm_reset_n_o
);

  // remaining stretch cycles
  logic [3:0] stretch_q;

  // reload while the command is held, then run down to zero
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      stretch_q <= `BRIDGE_RESET_STRETCH;
    end else if (stretch_q != 4'd0) begin
      stretch_q <= stretch_q - 4'd1;
    end
  end

  // chip reset is active low
  // low for the command plus exactly the stretch count after it
  assign slm_reset_n_o = !(reset_all_cmd_w || (stretch_q != 4'd0));

endmodule

`default_nettype wire

/* src/spi_frame_builder.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_frame_builder
  import uart_pkg::*, spi_pkg::*;
(
  input  logic       sys_clk,
  input  logic       reset_all_cmd_w,
  input  uart_byte_s rx_byte_i,
  output spi_req_s   spi_req_o
);

  logic       strobe_d_q;
  logic       rx_edge;
  // high when the next byte completes a pair
  logic       second_q;
  logic       start_q;
  spi_frame_u frame_q;

  assign rx_edge = rx_byte_i.strobe && !strobe_d_q;

  // pairing and start strobe
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      strobe_d_q <= 1'b0;
      second_q   <= 1'b0;
      start_q    <= 1'b0;
    end else begin
      strobe_d_q <= rx_byte_i.strobe;
      start_q    <= rx_edge && second_q;
      if (rx_edge) begin
        second_q <= !second_q;
      end
    end
  end

  // previous byte becomes the address, new byte the data
  always_ff @(posedge sys_clk) begin
    if (rx_edge) begin
      frame_q.fields.addr <= frame_q.fields.data;
      frame_q.fields.data <= rx_byte_i.data;
    end
  end

  assign spi_req_o.start = start_q;
  assign spi_req_o.frame = frame_q;

endmodule

`default_nettype wire

/* src/spi_master.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bridge_params.svh"

module spi_master
  import uart_pkg::*, spi_pkg::*;
(
  input  logic       sys_clk,
  input  logic       reset_all_cmd_w,
  input  spi_req_s   spi_req_i,
  input  logic       spi_miso_i,
  output logic       spi_mosi_o,
  output logic       spi_sclk_o,
  output logic       spi_cs_n_o,
  output uart_byte_s rd_byte_o
);

  localparam int HALF = `BRIDGE_SPI_HALF_PERIOD;
  localparam int BITS = `BRIDGE_FRAME_BITS;
  localparam int DIV_W = $clog2(HALF + 1);
  localparam int BIT_W = $clog2(BITS);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(HALF - 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(BITS - 1);

  logic             busy_q;
  // one cycle between the last sclk fall and cs release
  logic             tail_q;
  logic             cs_n_q;
  logic             sclk_q;
  logic [DIV_W-1:0] div_q;
  logic [BIT_W-1:0] bit_q;
  spi_frame_u       shift_q;
  logic             miso_q;
  logic             rd_strobe_q;
  logic [7:0]       rd_data_q;
  logic             start_ok;
  logic             half_end;
  logic             sclk_rise;
  logic             sclk_fall;

  assign start_ok  = !busy_q && spi_req_i.start;
  assign half_end  = busy_q && !tail_q && (div_q == DIV_LAST);
  assign sclk_rise = half_end && !sclk_q;
  assign sclk_fall = half_end && sclk_q;

  //////////////////////////////
  // clock divider and bit count
  always_ff @(posedge sys_clk) begin
    rd_strobe_q <= 1'b0;
    if (reset_all_cmd_w) begin
      busy_q <= 1'b0;
      tail_q <= 1'b0;
      cs_n_q <= 1'b1;
      sclk_q <= 1'b0;
      div_q  <= '0;
      bit_q  <= '0;
    end else if (start_ok) begin
      busy_q <= 1'b1;
      cs_n_q <= 1'b0;
      div_q  <= '0;
      bit_q  <= '0;
    end else if (tail_q) begin
      // busy falls together with the readback strobe
      tail_q      <= 1'b0;
      busy_q      <= 1'b0;
      cs_n_q      <= 1'b1;
      rd_strobe_q <= 1'b1;
    end else if (half_end) begin
      div_q  <= '0;
      sclk_q <= !sclk_q;
      if (sclk_fall) begin
        if (bit_q == BIT_LAST) begin
          tail_q <= 1'b1;
        end else begin
          bit_q <= bit_q + 1'b1;
        end
      end
    end else if (busy_q) begin
      div_q <= div_q + 1'b1;
    end
  end

  //////////////////////////////
  // shift path, mode 0
  // miso caught on the rise, shifted in on the fall
  always_ff @(posedge sys_clk) begin
    if (start_ok) begin
      shift_q <= spi_req_i.frame;
    end else if (sclk_rise) begin
      miso_q <= spi_miso_i;
    end else if (sclk_fall) begin
      shift_q.raw <= {shift_q.raw[BITS-2:0], miso_q};
    end
    // last eight samples hold the chip's reply
    if (tail_q) begin
      rd_data_q <= shift_q.raw[7:0];
    end
  end

  assign spi_mosi_o       = shift_q.raw[BITS-1];
  assign spi_sclk_o       = sclk_q;
  assign spi_cs_n_o       = cs_n_q;
  assign rd_byte_o.strobe = rd_strobe_q;
  assign rd_byte_o.data   = rd_data_q;

  // pairs arrive at uart rate, far slower than a frame
  a_no_start_while_busy : assert property (
    @(posedge sys_clk) disable iff (reset_all_cmd_w)
    spi_req_i.start |-> !busy_q
  ) else $error("spi_master start while busy");

endmodule

`default_nettype wire

/* src/spi_pkg.sv */
`default_nettype none

`include "bridge_params.svh"

// spi frame types for the display chip
package spi_pkg;

  // address goes out first, so it sits in the upper byte
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
  } spi_fields_s;

  // raw view for the shifter, field view for the byte pairing
  typedef union packed {
    logic [`BRIDGE_FRAME_BITS-1:0] raw;
    spi_fields_s                   fields;
  } spi_frame_u;

  // start strobe plus the frame it launches
  typedef struct packed {
    logic       start;
    spi_frame_u frame;
  } spi_req_s;

endpackage

`default_nettype wire

/* src/uart_pkg.sv */
`default_nettype none

// serial byte traffic between uart and spi stages
package uart_pkg;

  // one received or returned byte
  // strobe high for a single sys_clk cycle
  typedef struct packed {
    logic       strobe;
    logic [7:0] data;
  } uart_byte_s;

endpackage

`default_nettype wire

/* src/uart_rx.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_rx
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic       sys_clk,
  input  logic       reset_all_cmd_w,
  input  logic       uart_rx_i,
  output uart_byte_s rx_byte_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] CNT_MID = CNT_W'((CLKS_PER_BIT - 1) / 2);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e        state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       idx_q;
  logic             meta_q;
  logic             line_q;
  logic             strobe_q;
  logic [7:0]       data_q;

  //////////////////////////////
  // line sync and bit framing
  always_ff @(posedge sys_clk) begin
    // strobe lasts one cycle only
    strobe_q <= 1'b0;
    if (reset_all_cmd_w) begin
      meta_q  <= 1'b1;
      line_q  <= 1'b1;
      state_q <= RX_IDLE;
      cnt_q   <= '0;
      idx_q   <= 3'd0;
    end else begin
      // two flops against metastability
      meta_q <= uart_rx_i;
      line_q <= meta_q;
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (!line_q) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // start bit must still be low at its middle
          if (cnt_q == CNT_MID) begin
            cnt_q   <= '0;
            idx_q   <= 3'd0;
            state_q <= line_q ? RX_IDLE : RX_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (cnt_q == CNT_LAST) begin
            cnt_q <= '0;
            idx_q <= idx_q + 3'd1;
            if (idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          // stop bit middle, framing check
          if (cnt_q == CNT_LAST) begin
            strobe_q <= line_q;
            state_q  <= RX_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  // data bits, lsb first
  always_ff @(posedge sys_clk) begin
    if (state_q == RX_DATA && cnt_q == CNT_LAST) begin
      data_q[idx_q] <= line_q;
    end
  end

  assign rx_byte_o.strobe = strobe_q;
  assign rx_byte_o.data   = data_q;

endmodule

`default_nettype wire

/* src/uart_tx.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_tx
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic       sys_clk,
  input  logic       reset_all_cmd_w,
  input  uart_byte_s tx_byte_i,
  output logic       uart_tx_o,
  output logic       tx_active_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

  tx_state_e        state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       idx_q;
  logic [7:0]       data_q;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state_q     <= TX_IDLE;
      cnt_q       <= '0;
      idx_q       <= 3'd0;
      uart_tx_o   <= 1'b1;
      tx_active_o <= 1'b0;
    end else if (state_q == TX_IDLE) begin
      cnt_q <= '0;
      if (tx_byte_i.strobe) begin
        // start bit from the next cycle
        state_q     <= TX_START;
        uart_tx_o   <= 1'b0;
        tx_active_o <= 1'b1;
      end
    end else if (cnt_q != CNT_LAST) begin
      cnt_q <= cnt_q + 1'b1;
    end else begin
      // bit boundary
      cnt_q <= '0;
      case (state_q)
        TX_START: begin
          idx_q     <= 3'd0;
          uart_tx_o <= data_q[0];
          state_q   <= TX_DATA;
        end
        TX_DATA: begin
          idx_q <= idx_q + 3'd1;
          if (idx_q == 3'd7) begin
            uart_tx_o <= 1'b1;
            state_q   <= TX_STOP;
          end else begin
            uart_tx_o <= data_q[idx_q + 3'd1];
          end
        end
        default: begin
          // stop bit done, line stays high
          state_q     <= TX_IDLE;
          tx_active_o <= 1'b0;
        end
      endcase
    end
  end

  // byte held for the whole frame
  always_ff @(posedge sys_clk) begin
    if (state_q == TX_IDLE && tx_byte_i.strobe) begin
      data_q <= tx_byte_i.data;
    end
  end

  // queue must wait for the previous frame
  a_no_start_while_active : assert property (
    @(posedge sys_clk) disable iff (reset_all_cmd_w)
    tx_byte_i.strobe |-> !tx_active_o
  ) else $error("uart_tx start while active");

endmodule

`default_nettype wire

/* tests/tb_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bridge_params.svh"

module tb_bridge;

  localparam int CLKS_PER_BIT   = `BRIDGE_CLKS_PER_BIT;
  localparam int CLK_PERIOD_NS  = 20;
  localparam int STRETCH_CYCLES = 10;
  // 40 byte times of ten bits each, plus margin
  localparam int WATCHDOG_NS = 40 * 10 * CLKS_PER_BIT * CLK_PERIOD_NS + 200000;

  logic sys_clk;
  logic reset_all_cmd_w;
  logic reset_req = 1'b0;
  logic uart_line = 1'b1;
  logic miso = 1'b0;
  logic uart_tx_o;
  logic spi_mosi_o;
  logic spi_sclk_o;
  logic spi_cs_n_o;
  logic slm_reset_n_o;

  // expected traffic, written only by the stimulus
  logic [15:0] exp_frames[$];
  logic [7:0]  exp_readback[$];
  logic [7:0]  got_readback[$];
  logic [7:0]  addr_byte;
  logic        have_addr = 1'b0;
  integer      seed;
  int          rand_word;
  int          frames_before;
  int          p;

  // one counter per checking process
  int errors_reset = 0;
  int errors_frame = 0;
  int errors_readback = 0;
  int errors_flow = 0;

  // reset checker state
  int   low_cycles = 0;
  logic rst_prev = 1'b0;
  logic exp_slm;

  // spi slave state
  logic        cs_prev = 1'b1;
  logic        sclk_prev = 1'b0;
  logic [15:0] frame_bits = '0;
  logic [7:0]  reply = '0;
  int          rise_cnt = 0;
  int          frames_seen = 0;

  // uart monitor state
  logic [7:0] mon_bits;
  int         mon_i;
  int         readbacks_seen = 0;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (16)
  ) clock_gen0 (
    .reset_req_i     (reset_req),
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w)
  );

  bridge_top dut0 (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_line),
    .uart_tx_o       (uart_tx_o),
    .spi_miso_i      (miso),
    .spi_mosi_o      (spi_mosi_o),
    .spi_sclk_o      (spi_sclk_o),
    .spi_cs_n_o      (spi_cs_n_o),
    .slm_reset_n_o   (slm_reset_n_o)
  );

  //////////////////////////////
  // reset state and chip reset stretch
  always @(posedge sys_clk) begin
    exp_slm = reset_all_cmd_w ? 1'b0 : (low_cycles >= STRETCH_CYCLES);
    assert (slm_reset_n_o == exp_slm) else begin
      errors_reset++;
      $display("Fail at %0t: slm_reset_n_o expected %b got %b", $time, exp_slm, slm_reset_n_o);
    end
    // idle levels once reset has taken hold, and shortly after release
    if ((reset_all_cmd_w && rst_prev) || (!reset_all_cmd_w && low_cycles < STRETCH_CYCLES)) begin
      assert (uart_tx_o == 1'b1) else begin
        errors_reset++;
        $display("Fail at %0t: uart_tx_o expected 1 got %b", $time, uart_tx_o);
      end
      assert (spi_cs_n_o == 1'b1) else begin
        errors_reset++;
        $display("Fail at %0t: spi_cs_n_o expected 1 got %b", $time, spi_cs_n_o);
      end
    end
    if (reset_all_cmd_w) begin
      low_cycles = 0;
    end else if (low_cycles < 1000) begin
      low_cycles = low_cycles + 1;
    end
    rst_prev = reset_all_cmd_w;
  end

  //////////////////////////////
  // spi slave, mode 0
  // edges seen on the falling sys_clk, where sclk and cs are stable
  always @(negedge sys_clk) begin
    if (!spi_cs_n_o && cs_prev) begin
      rise_cnt   = 0;
      frame_bits = '0;
      miso       = 1'b0;
    end
    if (!spi_cs_n_o && spi_sclk_o && !sclk_prev) begin
      frame_bits = {frame_bits[14:0], spi_mosi_o};
      rise_cnt   = rise_cnt + 1;
      // address complete, answer with its inverse
      if (rise_cnt == 8) begin
        reply = ~frame_bits[7:0];
      end
    end
    if (!spi_cs_n_o && !spi_sclk_o && sclk_prev && rise_cnt >= 8 && rise_cnt < 16) begin
      miso  = reply[7];
      reply = {reply[6:0], 1'b0};
    end
    // cs release ends the frame
    if (spi_cs_n_o && !cs_prev) begin
      assert (rise_cnt == 16) else begin
        errors_frame++;
        $display("Fail at %0t: spi_sclk_o rising edges expected 16 got %0d", $time, rise_cnt);
      end
      if (frames_seen < exp_frames.size()) begin
        assert (frame_bits == exp_frames[frames_seen]) else begin
          errors_frame++;
          $display("Fail at %0t: spi_mosi_o frame expected %h got %h",
                   $time, exp_frames[frames_seen], frame_bits);
        end
      end else begin
        errors_frame++;
        $display("SPI frame appeared with no byte pair sent for it");
      end
      frames_seen = frames_seen + 1;
    end
    cs_prev   = spi_cs_n_o;
    sclk_prev = spi_sclk_o;
  end

  //////////////////////////////
  // uart monitor on the readback line
  initial begin
    forever begin
      @(negedge sys_clk);
      if (!uart_tx_o) begin
        // middle of the start bit
        repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);
        assert (!uart_tx_o) else begin
          errors_readback++;
          $display("start bit on uart_tx_o did not stay low");
        end
        for (mon_i = 0; mon_i < 8; mon_i++) begin
          repeat (CLKS_PER_BIT) @(negedge sys_clk);
          mon_bits = {uart_tx_o, mon_bits[7:1]};
        end
        repeat (CLKS_PER_BIT) @(negedge sys_clk);
        assert (uart_tx_o) else begin
          errors_readback++;
          $display("stop bit on uart_tx_o missing");
        end
        got_readback.push_back(mon_bits);
        if (readbacks_seen < exp_readback.size()) begin
          assert (mon_bits == exp_readback[readbacks_seen]) else begin
            errors_readback++;
            $display("Fail at %0t: uart_tx_o byte expected %h got %h",
                     $time, exp_readback[readbacks_seen], mon_bits);
          end
        end else begin
          errors_readback++;
          $display("readback byte arrived with no frame to answer");
        end
        readbacks_seen = readbacks_seen + 1;
      end
    end
  end

  //////////////////////////////
  // stimulus

  // one uart byte, lsb first, one stop bit
  task send_byte(input logic [7:0] value);
    logic [7:0] bits;
    int         i;
    bits = value;
    uart_line = 1'b0;
    repeat (CLKS_PER_BIT) @(negedge sys_clk);
    for (i = 0; i < 8; i++) begin
      uart_line = bits[0];
      bits = bits >> 1;
      repeat (CLKS_PER_BIT) @(negedge sys_clk);
    end
    uart_line = 1'b1;
    repeat (CLKS_PER_BIT) @(negedge sys_clk);
  endtask

  // second byte of a pair sets up the expected frame before it goes out
  task send_paired_byte(input logic [7:0] value);
    if (have_addr) begin
      exp_frames.push_back({addr_byte, value});
      exp_readback.push_back(~addr_byte);
    end else begin
      addr_byte = value;
    end
    have_addr = !have_addr;
    send_byte(value);
  endtask

  task wait_for_readbacks;
    while (readbacks_seen != exp_readback.size()) begin
      @(negedge sys_clk);
    end
  endtask

  initial begin
    seed = 32'hcae7ab8b;
    wait (!reset_all_cmd_w);
    repeat (20) @(negedge sys_clk);

    // lone address byte must not start a frame
    frames_before = frames_seen;
    send_paired_byte(8'h3c);
    repeat (2 * CLKS_PER_BIT) @(negedge sys_clk);
    assert (frames_seen == frames_before) else begin
      errors_flow++;
      $display("SPI frame started after a single byte");
    end
    send_paired_byte(8'ha5);
    wait_for_readbacks();

    // six random pairs back to back
    for (p = 0; p < 12; p++) begin
      rand_word = $random(seed);
      send_paired_byte(rand_word[7:0]);
    end
    wait_for_readbacks();

    // reset between the two bytes of a pair
    send_paired_byte(8'h5a);
    repeat (10) @(negedge sys_clk);
    reset_req = 1'b1;
    have_addr = 1'b0;
    repeat (5) @(negedge sys_clk);
    reset_req = 1'b0;
    repeat (20) @(negedge sys_clk);
    send_paired_byte(8'hc3);
    send_paired_byte(8'h18);
    wait_for_readbacks();

    // room for any stray frame or byte
    repeat (2 * CLKS_PER_BIT) @(negedge sys_clk);
    assert (frames_seen == exp_frames.size()) else begin
      errors_flow++;
      $display("Fail at %0t: frame count expected %0d got %0d",
               $time, exp_frames.size(), frames_seen);
    end
    assert (got_readback.size() == 8) else begin
      errors_flow++;
      $display("Fail at %0t: readback count expected 8 got %0d", $time, got_readback.size());
    end

    $display("errors: reset %0d, frame %0d, readback %0d, flow %0d",
             errors_reset, errors_frame, errors_readback, errors_flow);
    if (errors_reset + errors_frame + errors_readback + errors_flow == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the test sequence finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 16
) (
  input  logic reset_req_i,
  output logic sys_clk,
  output logic reset_all_cmd_w
);

  // power-on part of the reset
  logic por_q;

  initial begin
    sys_clk = 1'b0;
    forever #(PERIOD_NS / 2) sys_clk = ~sys_clk;
  end

  // release on a falling edge, away from the dut's sampling edge
  initial begin
    por_q = 1'b1;
    repeat (RESET_CYCLES) @(posedge sys_clk);
    @(negedge sys_clk);
    por_q = 1'b0;
  end

  // later resets come from the test sequence
  assign reset_all_cmd_w = por_q || reset_req_i;

endmodule

`default_nettype wire
